//--- compile.f
design/letc_pkg.sv
design/core_pkg.sv
design/core_s1_control.sv
design/core_s1.sv
design/fetch_imem.sv
design/core_s2_decode.sv
design/letc_fetch_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_fetch -o tb_fetch_sim
./obj_dir/tb_fetch_sim | tee sim.log

if grep -qF "** FAIL **" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failures"

//--- verif/tb_fetch.sv
// Fetch front end testbench
// Loads a program while reset is held, then runs a table of ready, trap and
// halt rows against the DUT while the checker compares the output stream

`timescale 1ns/10ps

module tb_fetch;
    import letc_pkg::*;
    import core_pkg::*;

    typedef struct packed {
        logic [15:0] cycles;
        logic        always_ready;  // Else ready comes from the LCG
        logic        trap;          // Pulse in the first cycle of the row
        word_t       target;
        logic        halt;          // Pulse in the first cycle of the row
    } stim_row_s;

    logic clk, rst_n, hold_rst;
    logic halt_req, trap_occurred, load_en, out_ready, out_valid;
    word_t trap_target_addr, load_addr, load_data;
    s2_out_s out_data;
    word_t prog [IMEM_DEPTH];
    int row_idx, error_count, cycle_count, cycle_limit;
    logic row_end, run_done;
    word_t lcg_state;

    //                    cycles rdy   trap  target         halt
    stim_row_s stim_tbl [9] = '{
        '{16'd30, 1'b1, 1'b0, 32'h0000_0000, 1'b0},  // Sequential run through both JALs
        '{16'd60, 1'b0, 1'b0, 32'h0000_0000, 1'b0},  // Random back-pressure
        '{16'd12, 1'b0, 1'b1, 32'h0000_0080, 1'b0},
        '{16'd40, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{16'd12, 1'b1, 1'b1, 32'h0000_0024, 1'b0},  // Trap lands on a JAL
        '{16'd40, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{16'd15, 1'b0, 1'b1, 32'h0000_01c0, 1'b0},  // Target past the array, index wraps
        '{16'd30, 1'b0, 1'b0, 32'h0000_0000, 1'b0},
        '{16'd20, 1'b1, 1'b0, 32'h0000_0000, 1'b1}   // Halt, drain then silence
    };

    function automatic word_t make_jal(input int offset, input logic [4:0] rd);
        logic [20:0] imm;
        imm = 21'(offset);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fill_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = {12'(i * 5 + 1), 5'd1, 3'b000, 5'd1, 7'b0010011};  // addi x1, x1, imm
        end
        prog[2]  = {12'd8, 5'd0, 3'b010, 5'd2, 7'b0000011};          // lw x2, 8(x0)
        prog[5]  = {7'd0, 5'd2, 5'd0, 3'b010, 5'd12, 7'b0100011};    // sw x2, 12(x0)
        prog[7]  = {7'd0, 5'd3, 5'd4, 3'b000, 5'd8, 7'b1100011};     // beq, never resolved
        prog[9]  = make_jal(24, 5'd1);                               // To 0x3c
        prog[12] = {7'd0, 5'd3, 5'd2, 3'b110, 5'd1, 7'b0110011};     // or x1, x2, x3
        prog[20] = {20'h12345, 5'd6, 7'b0110111};                    // lui, class other
        prog[26] = make_jal(64, 5'd0);                               // To 0xa8
        prog[44] = {12'd4, 5'd1, 3'b010, 5'd7, 7'b0000011};
        prog[47] = {7'd0, 5'd7, 5'd1, 3'b010, 5'd0, 7'b0100011};
        prog[55] = {7'd0, 5'd1, 5'd2, 3'b001, 5'd4, 7'b1100011};     // bne
    endtask

    task automatic apply_row(input stim_row_s row, input int r);
        int n;
        n = int'(row.cycles);
        for (int c = 0; c < n; c++) begin
            @(negedge clk);
            lcg_state        = lcg_next(lcg_state);
            out_ready        = row.always_ready | (lcg_state[30:29] != 2'b00);  // 3 in 4
            trap_occurred    = row.trap & (c == 0);
            trap_target_addr = row.target;
            halt_req         = row.halt & (c == 0);
            row_idx          = r;
            row_end          = (c == n - 1);
        end
    endtask

    initial begin : stimulus
        int total;
        halt_req = 1'b0;
        trap_occurred = 1'b0;
        trap_target_addr = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        out_ready = 1'b0;
        hold_rst = 1'b1;
        row_idx = 0;
        row_end = 1'b0;
        run_done = 1'b0;
        cycle_count = 0;
        lcg_state = 32'haea6;
        fill_program();
        total = 0;
        foreach (stim_tbl[r]) total += int'(stim_tbl[r].cycles);
        cycle_limit = IMEM_DEPTH + 12 + total + 100;  // Load, reset, rows, margin
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = 32'(i * 4);
            load_data = prog[i];
        end
        @(negedge clk);
        load_en  = 1'b0;
        hold_rst = 1'b0;
        @(posedge rst_n);
        foreach (stim_tbl[r]) apply_row(stim_tbl[r], r);
        @(negedge clk);
        trap_occurred = 1'b0;
        halt_req      = 1'b0;
        row_end       = 1'b0;
        run_done      = 1'b1;   // Checker prints its totals on the next edge
        @(negedge clk);
        run_done = 1'b0;
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end : stimulus

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end : watchdog

    tb_clkgen clock_gen (.clk(clk), .rst_n(rst_n), .hold_rst(hold_rst));

    letc_fetch_top UUT (
        .clk (clk), .rst_n (rst_n), .halt_req (halt_req),
        .trap_occurred (trap_occurred), .trap_target_addr (trap_target_addr),
        .load_en (load_en), .load_addr (load_addr), .load_data (load_data),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data)
    );

    tb_checker result_check (
        .clk (clk), .rst_n (rst_n), .prog (prog),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .trap_occurred (trap_occurred), .trap_target_addr (trap_target_addr),
        .halt_req (halt_req), .row_idx (row_idx), .row_end (row_end),
        .run_done (run_done), .error_count (error_count)
    );

endmodule : tb_fetch

//--- verif/tb_checker.sv
// Fetch output checker
// Walks a reference PC model over the program image at each output handshake
// and also watches hold stability, traps and halt

`timescale 1ns/10ps

module tb_checker (
    input   logic                   clk,
    input   logic                   rst_n,
    input   letc_pkg::word_t        prog [letc_pkg::IMEM_DEPTH],
    input   logic                   out_valid,
    input   logic                   out_ready,
    input   core_pkg::s2_out_s      out_data,
    input   logic                   trap_occurred,
    input   letc_pkg::word_t        trap_target_addr,
    input   logic                   halt_req,
    input   int                     row_idx,
    input   logic                   row_end,        // Last cycle of a stimulus row
    input   logic                   run_done,
    output  int                     error_count
);
    import letc_pkg::*;
    import core_pkg::*;

    word_t      expected_pc = RESET_PC;  // Next PC the stream must show
    logic       trap_pending = 1'b0;     // Held item still ahead of the trap target
    word_t      pending_target;
    logic       held = 1'b0;
    s2_out_s    held_data;
    logic       halted = 1'b0;
    logic       drained = 1'b0;          // Output went quiet after halt
    int         after_halt = 0;
    int         row_outputs = 0;
    int         row_errors = 0;
    int         total_outputs = 0;

    initial error_count = 0;

    // Instruction class from bits 6:0
    function automatic opcode_e expected_class(input word_t instr);
        case (instr[6:0])
            7'b1101111:             return OP_JAL;
            7'b0110011, 7'b0010011: return OP_ALU;
            7'b0000011:             return OP_LOAD;
            7'b0100011:             return OP_STORE;
            7'b1100011:             return OP_BRANCH;
            default:                return OP_OTHER;
        endcase
    endfunction

    // J-type offset, each immediate field placed at its ISA position
    function automatic word_t jal_offset(input word_t instr);
        logic [20:0] imm;
        imm        = '0;
        imm[20]    = instr[31];
        imm[10:1]  = instr[30:21];
        imm[11]    = instr[20];
        imm[19:12] = instr[19:12];
        return word_t'($signed(imm));
    endfunction

    task automatic fail_value(input string msg);
        $display("FAILED @%0t: %s", $time, msg);
        error_count++;
        row_errors++;
    endtask

    task automatic fail_event(input string msg);
        $display("Check error at %0t ns: %s", $time, msg);
        error_count++;
        row_errors++;
    endtask

    task automatic check_item();
        word_t   exp_instr;
        opcode_e exp_op;
        exp_instr = prog[expected_pc[IMEM_AW+1:2]];  // Upper bits wrap
        exp_op    = expected_class(exp_instr);
        if (out_data.pc !== expected_pc)
            fail_value($sformatf("pc got %h expected %h", out_data.pc, expected_pc));
        if (out_data.instr !== exp_instr)
            fail_value($sformatf("instr got %h expected %h", out_data.instr, exp_instr));
        if (out_data.op !== exp_op)
            fail_value($sformatf("op got %0d expected %0d", out_data.op, exp_op));
        if (trap_pending) begin
            expected_pc  = pending_target;  // Last item before the trap is out
            trap_pending = 1'b0;
        end else if (exp_op == OP_JAL) begin
            expected_pc = expected_pc + jal_offset(exp_instr);
        end else begin
            expected_pc = expected_pc + 32'd4;
        end
    endtask

    always @(posedge clk) begin : watch
        if (~rst_n) begin
            if (out_valid === 1'b1) fail_event("out_valid high during reset");
        end else begin
            if (held && (out_valid !== 1'b1 || out_data !== held_data))
                fail_value("output changed while stalled");
            if (halt_req) halted = 1'b1;
            if (drained && out_valid !== 1'b0)
                fail_event("out_valid rose again after the halt drained");
            if (out_valid && out_ready) begin
                check_item();
                row_outputs++;
                total_outputs++;
                if (halted) after_halt++;
                if (after_halt > 2) fail_event("more than two outputs delivered after halt");
            end
            if (halted && !halt_req && out_valid === 1'b0) drained = 1'b1;
            if (trap_occurred) begin
                if (out_valid && !out_ready) begin
                    trap_pending   = 1'b1;  // S2 still owes its item first
                    pending_target = trap_target_addr;
                end else begin
                    trap_pending = 1'b0;
                    expected_pc  = trap_target_addr;
                end
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
        end
        if (row_end) begin
            if (halted && out_valid) fail_event("out_valid still high at the end of the halt row");
            if (!halted && row_outputs == 0) fail_event("no output handshake in this row");
            $display("row %0d done: %0d outputs, %0d errors", row_idx, row_outputs, row_errors);
            row_outputs = 0;
            row_errors  = 0;
        end
        if (run_done) $display("all rows: %0d outputs, %0d errors", total_outputs, error_count);
    end : watch

endmodule : tb_checker

//--- verif/tb_clkgen.sv
// Testbench clock and reset
// 10 ns clock, reset held through the program load and for 10 cycles after it

`timescale 1ns/10ps

module tb_clkgen (
    output  logic   clk,
    output  logic   rst_n,
    input   logic   hold_rst    // Program load still running
);
    int low_cycles;

    initial begin : clock
        clk = 1'b0;
        forever #5 clk = ~clk;
    end : clock

    initial begin : reset_seq
        rst_n      = 1'b0;
        low_cycles = 0;
        while (low_cycles < 10) begin
            @(posedge clk);
            low_cycles = hold_rst ? 0 : low_cycles + 1; // Count only once load is over
        end
        @(negedge clk);
        rst_n = 1'b1;   // Release away from the active edge
    end : reset_seq

endmodule : tb_clkgen

//--- design/letc_fetch_top.sv
// Instruction fetch front end
// S1 fetch, instruction memory and S2 decode tied together

`timescale 1ns/10ps

module letc_fetch_top (
    input   logic                   clk,
    input   logic                   rst_n,

    input   logic                   halt_req,
    input   logic                   trap_occurred,
    input   letc_pkg::word_t        trap_target_addr,

    // Program load, used while reset is held
    input   logic                   load_en,
    input   letc_pkg::word_t        load_addr,
    input   letc_pkg::word_t        load_data,

    output  logic                   out_valid,
    input   logic                   out_ready,
    output  core_pkg::s2_out_s      out_data
);
    import letc_pkg::*;
    import core_pkg::*;

    word_t      fetch_addr;
    word_t      imem_rdata;
    s1_to_s2_s  s1_to_s2;
    s2_to_s1_s  s2_to_s1;
    logic       s2_busy;

    core_s1 core_s1_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .halt_req         (halt_req),
        .s2_busy          (s2_busy),
        .trap_occurred    (trap_occurred),
        .trap_target_addr (trap_target_addr),
        .fetch_addr       (fetch_addr),
        .imem_rdata       (imem_rdata),
        .s1_to_s2         (s1_to_s2),
        .s2_to_s1         (s2_to_s1)
    );

    fetch_imem fetch_imem_inst (
        .clk        (clk),
        .fetch_addr (fetch_addr),
        .rdata      (imem_rdata),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    core_s2_decode core_s2_decode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .s1_to_s2   (s1_to_s2),
        .s2_busy    (s2_busy),
        .s2_to_s1   (s2_to_s1),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

endmodule : letc_fetch_top

//--- design/core_s2_decode.sv
// S2 decode stage
// Registers each accepted instruction with its opcode class and offers it
// downstream on valid/ready. A JAL redirects S1 in the cycle it is accepted

`timescale 1ns/10ps

module core_s2_decode (
    input   logic                   clk,
    input   logic                   rst_n,

    input   core_pkg::s1_to_s2_s    s1_to_s2,
    output  logic                   s2_busy,      // Back-pressure to S1
    output  core_pkg::s2_to_s1_s    s2_to_s1,

    // Downstream handshake
    output  logic                   out_valid,
    input   logic                   out_ready,
    output  core_pkg::s2_out_s      out_data
);
    import letc_pkg::*;
    import core_pkg::*;

    logic       valid_ff;
    s2_out_s    out_ff;     // Payload, no reset needed

    logic       accept;
    opcode_e    in_op;      // Class of the incoming candidate
    word_t      j_imm;
    word_t      in_instr;

    // Full and not draining this cycle
    assign s2_busy = valid_ff & ~out_ready;
    assign accept  = s1_to_s2.valid & ~s2_busy;

    assign in_instr = s1_to_s2.instr;
    assign in_op    = classify_opcode(in_instr);

    // J-type immediate, imm[20|10:1|11|19:12]
    assign j_imm = {
        {12{in_instr[31]}},
        in_instr[19:12],
        in_instr[20],
        in_instr[30:21],
        1'b0
    };

    // Same-cycle jump so S1 never fetches past a JAL
    assign s2_to_s1 = '{
        redirect:      accept & (in_op == OP_JAL),
        redirect_addr: s1_to_s2.pc + j_imm
    };

    always_ff @(posedge clk, negedge rst_n) begin : valid_seq
        if (~rst_n) begin
            valid_ff <= 1'b0;
        end else if (~s2_busy) begin
            valid_ff <= s1_to_s2.valid; // Refill or go empty
        end
    end : valid_seq

    always_ff @(posedge clk) begin : payload_seq
        if (accept) begin
            out_ff <= '{
                pc:    s1_to_s2.pc,
                instr: in_instr,
                op:    in_op
            };
        end
    end : payload_seq

    assign out_valid = valid_ff;
    assign out_data  = out_ff;  // Stable while stalled since accept is low

endmodule : core_s2_decode

//--- design/fetch_imem.sv
// Instruction memory for the fetch stage
// Synchronous read, plus a write port used to load the program during reset

`timescale 1ns/10ps

module fetch_imem (
    input   logic               clk,

    input   letc_pkg::word_t    fetch_addr,   // Byte address
    output  letc_pkg::word_t    rdata,        // Registered read data

    // Program load, one word per cycle
    input   logic               load_en,
    input   letc_pkg::word_t    load_addr,    // Byte address
    input   letc_pkg::word_t    load_data
);
    import letc_pkg::*;

    word_t              mem [IMEM_DEPTH];
    logic [IMEM_AW-1:0] rd_idx;
    logic [IMEM_AW-1:0] wr_idx;

    // Drop byte offset, upper bits wrap around the array
    assign rd_idx = fetch_addr[IMEM_AW+WORD_LSB-1:WORD_LSB];
    assign wr_idx = load_addr[IMEM_AW+WORD_LSB-1:WORD_LSB];

    always_ff @(posedge clk) begin : mem_write
        if (load_en) begin
            mem[wr_idx] <= load_data;
        end
    end : mem_write

    // Read data appears the cycle after the address
    always_ff @(posedge clk) begin : mem_read
        rdata <= mem[rd_idx];
    end : mem_read

endmodule : fetch_imem

//--- design/core_s1.sv
// S1 fetch stage
// Holds the PC, picks the next PC from trap, jump redirect or sequential,
// drives the instruction memory address and forms the candidate for S2

`timescale 1ns/10ps

module core_s1 (
    input   logic                   clk,
    input   logic                   rst_n,

    input   logic                   halt_req,
    input   logic                   s2_busy,          // S2 not ready for a new candidate
    input   logic                   trap_occurred,
    input   letc_pkg::word_t        trap_target_addr,

    // Instruction memory
    output  letc_pkg::word_t        fetch_addr,
    input   letc_pkg::word_t        imem_rdata,       // Word at last cycle's fetch_addr

    output  core_pkg::s1_to_s2_s    s1_to_s2,
    input   core_pkg::s2_to_s1_s    s2_to_s1
);
    import letc_pkg::*;

    // Controls from the FSM
    logic   s1_stall;
    logic   bypass_pc_for_fetch_addr;
    logic   fetch_valid;

    word_t  pc_ff;
    word_t  next_pc;
    word_t  next_seq_pc;

    // PC register
    always_ff @(posedge clk, negedge rst_n) begin : pc_seq
        if (~rst_n) begin
            pc_ff <= RESET_PC;
        end else if (~s1_stall) begin
            pc_ff <= next_pc;
        end
    end : pc_seq

    assign next_seq_pc = pc_ff + INSTR_BYTES;

    // Trap beats redirect beats sequential
    always_comb begin : next_pc_comb
        if (trap_occurred) begin
            next_pc = trap_target_addr;
        end else if (s2_to_s1.redirect) begin
            next_pc = s2_to_s1.redirect_addr; // JAL accepted this cycle
        end else begin
            next_pc = next_seq_pc;
        end
    end : next_pc_comb

    // Read one cycle ahead so the returned word lines up with pc_ff
    assign fetch_addr = bypass_pc_for_fetch_addr ? next_pc : pc_ff;

    // The candidate always carries pc_ff, the memory word belongs to it
    assign s1_to_s2 = '{
        valid: fetch_valid,
        pc:    pc_ff,
        instr: imem_rdata
    };

    core_s1_control core_s1_control_inst (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .halt_req                 (halt_req),
        .s2_busy                  (s2_busy),
        .trap_occurred            (trap_occurred),
        .s1_stall                 (s1_stall),
        .bypass_pc_for_fetch_addr (bypass_pc_for_fetch_addr),
        .fetch_valid              (fetch_valid)
    );

endmodule : core_s1

//--- design/core_s1_control.sv
// S1 fetch control
// Runs the reset/run/halted FSM and derives stall, fetch-address bypass
// and the squash-aware valid for the S1 candidate

`timescale 1ns/10ps

module core_s1_control (
    input   logic   clk,
    input   logic   rst_n,

    input   logic   halt_req,       // Stop fetching until reset
    input   logic   s2_busy,        // S2 cannot take the candidate this cycle
    input   logic   trap_occurred,  // Redirect to trap target, squash candidate

    output  logic   s1_stall,
    output  logic   bypass_pc_for_fetch_addr,
    output  logic   fetch_valid
);
    import core_pkg::*;

    fetch_state_e state_ff;
    fetch_state_e state_next;
    logic         running;

    always_ff @(posedge clk, negedge rst_n) begin : state_seq
        if (~rst_n) begin
            state_ff <= FS_RESET;
        end else begin
            state_ff <= state_next;
        end
    end : state_seq

    always_comb begin : state_comb
        state_next = state_ff; // Hold by default
        case (state_ff)
            FS_RESET: begin
                // First word at RESET_PC is being read this cycle
                state_next = halt_req ? FS_HALTED : FS_RUN;
            end
            FS_RUN: begin
                if (halt_req) begin
                    state_next = FS_HALTED;
                end
            end
            FS_HALTED: state_next = FS_HALTED; // Only reset leaves
            default:   state_next = FS_RESET;
        endcase
    end : state_comb

    assign running = (state_ff == FS_RUN);

    // A trap never offers a candidate, so it may move the PC even when S2 is full
    assign s1_stall = ~running | (s2_busy & ~trap_occurred);

    // Present next PC to memory whenever the PC will advance
    assign bypass_pc_for_fetch_addr = ~s1_stall;

    // Squash the candidate on a trap
    assign fetch_valid = running & ~trap_occurred;

endmodule : core_s1_control

//--- design/core_pkg.sv
// Fetch pipeline types
// Stage-to-stage structs, FSM states and the opcode classes seen by decode

package core_pkg;

    // RV32 major opcodes, bits 6:0 of the instruction
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate ALU
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // Coarse instruction class handed downstream
    typedef enum logic [2:0] {
        OP_JAL,
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_OTHER
    } opcode_e;

    // S1 fetch FSM
    typedef enum logic [1:0] {
        FS_RESET,   // One idle cycle while the first word is read
        FS_RUN,
        FS_HALTED   // Sticky until reset
    } fetch_state_e;

    // Candidate instruction offered by S1
    typedef struct packed {
        logic           valid;
        letc_pkg::word_t pc;
        letc_pkg::word_t instr;
    } s1_to_s2_s;

    // Jump feedback from S2, combinational
    typedef struct packed {
        logic           redirect;
        letc_pkg::word_t redirect_addr;
    } s2_to_s1_s;

    // Decoded item leaving the fetch subsystem
    typedef struct packed {
        letc_pkg::word_t pc;
        letc_pkg::word_t instr;
        opcode_e        op;
    } s2_out_s;

    // Map bits 6:0 onto an opcode class
    function automatic opcode_e classify_opcode(input letc_pkg::word_t instr);
        case (instr[6:0])
            OPC_JAL:              return OP_JAL;
            OPC_OP, OPC_OP_IMM:   return OP_ALU;
            OPC_LOAD:             return OP_LOAD;
            OPC_STORE:            return OP_STORE;
            OPC_BRANCH:           return OP_BRANCH;
            default:              return OP_OTHER; // LUI, AUIPC, JALR, SYSTEM...
        endcase
    endfunction

endpackage : core_pkg

//--- design/letc_pkg.sv
// Core-wide definitions shared by every stage
// Word type, reset PC and instruction memory geometry

package letc_pkg;

    // Datapath width
    localparam int WORD_W = 32;

    // One data or address word
    typedef logic [WORD_W-1:0] word_t;

    // Where fetch begins after reset
    localparam word_t RESET_PC = 32'h0000_0000;

    // Byte step between sequential instructions
    localparam word_t INSTR_BYTES = 32'd4;

    // Instruction memory size in words
    localparam int IMEM_DEPTH = 64;

    // Word index width, log2 of the depth
    localparam int IMEM_AW = 6;

    // Lowest byte-address bit that selects a word
    localparam int WORD_LSB = 2;

endpackage : letc_pkg
